//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
TOP       ?= tb_melody_player
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Some tests failed
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
verilog/melody_pkg.sv
verilog/apb_regs.sv
verilog/beat_timer.sv
verilog/melody_fsm.sv
verilog/melody_rom.sv
verilog/tone_gen.sv
verilog/note_display.sv
verilog/melody_player.sv
testbench/melody_player_asserts.sv
testbench/tb_melody_player.sv

//--- testbench/melody_player_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module melody_player_asserts
    import melody_pkg::*;
#(
    parameter int w_sound = 16
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pready,
    input  logic                      start,
    input  logic                      stop,
    input  logic                      playing,
    input  note_index_t               index,
    input  logic signed [w_sound-1:0] sound
);

    // the slave never inserts wait states
    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready went low");

    // control strobes from CTRL last exactly one cycle
    a_start_pulse: assert property (@(posedge clk) disable iff (rst) start |=> !start)
        else $error("start pulse lasted more than one cycle");
    a_stop_pulse: assert property (@(posedge clk) disable iff (rst) stop |=> !stop)
        else $error("stop pulse lasted more than one cycle");

    // the speaker is quiet whenever the player is idle
    a_quiet_idle: assert property (@(posedge clk) disable iff (rst) !playing |-> sound == '0)
        else $error("sound nonzero while idle");

    a_index_range: assert property (@(posedge clk) disable iff (rst)
                                    index <= note_index_t'(song_len - 1))
        else $error("note index past the end of the song");

endmodule

// attached to every melody_player, internal ctrl and status are reached by name
bind melody_player melody_player_asserts #(
    .w_sound (w_sound)
) melody_player_asserts_i (
    .clk     (clk),
    .rst     (rst),
    .pready  (pready),
    .start   (ctrl.start),
    .stop    (ctrl.stop),
    .playing (status.playing),
    .index   (status.index),
    .sound   (sound)
);

`default_nettype wire

//--- testbench/tb_melody_player.sv
`timescale 1ns/1ps
`default_nettype none

module tb_melody_player
    import melody_pkg::*;
();

    localparam int w_sound     = 16;
    localparam int period      = 40;
    // short beat so whole songs fit in a few thousand cycles
    localparam int tempo_short = 15;

    logic                      clk;
    logic                      rst;
    logic [31:0]               paddr;
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [31:0]               pwdata;
    logic [31:0]               prdata;
    logic                      pready;
    logic                      pslverr;
    logic signed [w_sound-1:0] sound;
    logic [7:0]                abcdefgh;

    integer      seed;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    // results of the last bus access, sampled in its access phase
    logic [31:0] rd_data;
    logic        rd_err;
    logic [7:0]  rd_segs;
    // state shared with the sound comparing process
    logic        sound_check_en = 1'b0;
    volume_t     cur_volume = '0;
    logic        seen_pos = 1'b0;
    logic        seen_neg = 1'b0;

    melody_player #(
        .w_sound (w_sound)
    ) melody_player_i (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .sound    (sound),
        .abcdefgh (abcdefgh)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
    end

    // ----------------------------------------------------------
    // reference models
    // ----------------------------------------------------------

    // segments are listed by letter, a lands in bit 7 and the dot h in bit 0
    function automatic logic [7:0] seg_ref(input pitch_t pitch);
        string      lit;
        logic [7:0] segs;
        case (pitch)
            4'd0, 4'd1:  lit = "adef";
            4'd2, 4'd3:  lit = "bcdeg";
            4'd4:        lit = "adefg";
            4'd5, 4'd6:  lit = "aefg";
            4'd7, 4'd8:  lit = "acdef";
            4'd9, 4'd10: lit = "abcefg";
            4'd11:       lit = "cdefg";
            default:     lit = "";
        endcase
        segs = '0;
        for (int i = 0; i < lit.len(); i++) begin
            // 97 is the code of a
            segs[7 - (lit[i] - 8'd97)] = 1'b1;
        end
        // the dot marks the five sharps
        if (pitch inside {4'd1, 4'd3, 4'd6, 4'd8, 4'd10}) begin
            segs[0] = 1'b1;
        end
        return segs;
    endfunction

    function automatic logic [31:0] amp_ref(input volume_t volume, input int width);
        logic [31:0] full;
        full = (32'd1 << (width - 1)) - 32'd1;
        return full >> volume;
    endfunction

    // ----------------------------------------------------------
    // checking and bookkeeping
    // ----------------------------------------------------------
    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got 0x%0h, expected 0x%0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report_failure(input string what);
        $display("%0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s test: ok", name);
        end else begin
            tests_failed++;
            $display("%s test: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    // every nonzero sample must sit at the expected level
    always @(negedge clk) begin : sound_compare
        logic [31:0] mag;
        if (sound_check_en && sound != '0) begin
            mag = sound[w_sound-1] ? -32'(sound) : 32'(sound);
            check("sound magnitude", mag, amp_ref(cur_volume, w_sound));
            if (sound[w_sound-1]) begin
                seen_neg = 1'b1;
            end else begin
                seen_pos = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // APB access, driven on falling edges
    // ----------------------------------------------------------
    task automatic bus_access(input logic write, input logic [31:0] addr,
                              input logic [31:0] data);
        int n;
        n = 0;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #1;
        while (!pready && n < 16) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!pready) begin
            report_failure("APB access never saw pready");
        end
        rd_data = prdata;
        rd_err  = pslverr;
        rd_segs = abcdefgh;
        // the transfer completes on this edge
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        bus_access(1'b1, addr, data);
    endtask

    task automatic read_reg(input logic [31:0] addr);
        bus_access(1'b0, addr, 32'h0);
    endtask

    // ----------------------------------------------------------
    // tests
    // ----------------------------------------------------------
    task automatic check_registers();
        logic [31:0] val;
        read_reg(reg_tempo);
        check("TEMPO reset", rd_data, 32'h00FF_FFFF);
        read_reg(reg_volume);
        check("VOLUME reset", rd_data, 32'h0);
        repeat (4) begin
            val = $random(seed);
            write_reg(reg_tempo, val);
            read_reg(reg_tempo);
            check("TEMPO", rd_data, {8'h0, val[23:0]});
            check("pslverr", rd_err, 1'b0);
            val = $random(seed);
            write_reg(reg_volume, val);
            read_reg(reg_volume);
            check("VOLUME", rd_data, {28'h0, val[3:0]});
            // keep start and stop clear so nothing plays here
            val = $random(seed);
            write_reg(reg_ctrl, (val & ~32'h7) | 32'h4);
            read_reg(reg_ctrl);
            check("CTRL", rd_data, 32'h4);
        end
        write_reg(reg_ctrl, 32'h0);
        read_reg(reg_ctrl);
        check("CTRL", rd_data, 32'h0);
        write_reg(32'h10, $random(seed));
        check("pslverr on write", rd_err, 1'b1);
        read_reg(32'h10);
        check("pslverr on read", rd_err, 1'b1);
        check("unmapped read", rd_data, 32'h0);
    endtask

    task automatic play_one_shot();
        logic [31:0] prev;
        int          t0;
        write_reg(reg_tempo, tempo_short);
        write_reg(reg_ctrl, 32'h1);
        read_reg(reg_status);
        check("STATUS playing", rd_data[13], 1'b1);
        check("STATUS index", rd_data[12:7], 6'd0);
        prev = rd_data;
        t0   = cycles;
        while (rd_data[13] && cycles - t0 < song_len * (tempo_short + 1) + 200) begin
            read_reg(reg_status);
            if (rd_data[12:7] < prev[12:7]) begin
                report_failure("note index went backwards during one-shot playback");
            end
            prev = rd_data;
        end
        if (rd_data[13]) begin
            report_failure("one-shot playback did not end in time");
        end else begin
            check("STATUS index at end", rd_data[12:7], song_len - 1);
        end
        // the display register needs one more edge to blank
        repeat (2) @(negedge clk);
        check("abcdefgh idle", abcdefgh, 8'h0);
    endtask

    task automatic play_looped();
        logic [31:0] prev;
        logic        wrapped;
        int          t0;
        wrapped = 1'b0;
        write_reg(reg_ctrl, 32'h5);
        read_reg(reg_status);
        // the one-shot run left the index on the last note, so the start must clear it
        check("STATUS playing after start", rd_data[13], 1'b1);
        check("STATUS index after start", rd_data[12:7], 6'd0);
        prev = rd_data;
        t0   = cycles;
        while (!wrapped && cycles - t0 < 2 * song_len * (tempo_short + 1)) begin
            read_reg(reg_status);
            if (!rd_data[13]) begin
                report_failure("looped playback stopped on its own");
                break;
            end
            if (rd_data[12:7] < prev[12:7]) begin
                wrapped = 1'b1;
                check("index before wrap", prev[12:7], song_len - 1);
            end
            prev = rd_data;
        end
        if (!wrapped) begin
            report_failure("looped playback never wrapped to the start");
        end
        write_reg(reg_ctrl, 32'h2);
        read_reg(reg_status);
        check("STATUS playing after stop", rd_data[13], 1'b0);
    endtask

    task automatic watch_display();
        logic [31:0] prev;
        int          compared;
        int          t0;
        compared = 0;
        write_reg(reg_ctrl, 32'h1);
        read_reg(reg_status);
        prev = rd_data;
        t0   = cycles;
        // two equal STATUS reads mean the note held between them
        while (cycles - t0 < 40 * (tempo_short + 1)) begin
            read_reg(reg_status);
            if (rd_data == prev && rd_data[13]) begin
                check("abcdefgh", rd_segs, seg_ref(rd_data[3:0]));
                compared++;
            end
            prev = rd_data;
        end
        if (compared == 0) begin
            report_failure("no stable note was seen to compare the display");
        end
        write_reg(reg_ctrl, 32'h2);
        repeat (2) @(negedge clk);
        check("abcdefgh idle", abcdefgh, 8'h0);
    endtask

    task automatic measure_tone();
        volume_t     levels [3];
        logic [31:0] val;
        int          t0;
        val       = $random(seed);
        levels[0] = 4'd0;
        levels[1] = 4'd4;
        levels[2] = {1'b0, val[2:0]} + 4'd1;
        // long beats so the first note lasts several half periods
        write_reg(reg_tempo, 32'd200000);
        foreach (levels[i]) begin
            sound_check_en = 1'b0;
            write_reg(reg_volume, levels[i]);
            cur_volume = levels[i];
            write_reg(reg_ctrl, 32'h1);
            seen_pos       = 1'b0;
            seen_neg       = 1'b0;
            sound_check_en = 1'b1;
            t0             = cycles;
            while (!(seen_pos && seen_neg) && cycles - t0 < 150000) begin
                @(negedge clk);
            end
            if (!(seen_pos && seen_neg)) begin
                report_failure("sound did not swing both ways in time");
            end
            sound_check_en = 1'b0;
            write_reg(reg_ctrl, 32'h2);
            repeat (2) @(negedge clk);
            check("sound after stop", sound, 32'h0);
        end
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin : main
        int errors_before;
        seed    = 32'h4575;
        rst     = 1'b1;
        paddr   = 32'h0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'h0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        errors_before = errors;
        check_registers();
        close_test("registers", errors_before);
        errors_before = errors;
        play_one_shot();
        close_test("one-shot playback", errors_before);
        errors_before = errors;
        play_looped();
        close_test("loop mode", errors_before);
        errors_before = errors;
        watch_display();
        close_test("display", errors_before);
        errors_before = errors;
        measure_tone();
        close_test("tone level", errors_before);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/apb_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_regs
    import melody_pkg::*;
(
    input  logic           clk,
    input  logic           rst,
    input  logic [31:0]    paddr,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [31:0]    pwdata,
    output logic [31:0]    prdata,
    output logic           pready,
    output logic           pslverr,
    output player_ctrl_t   ctrl,
    input  player_status_t status
);

    logic    hit_ctrl;
    logic    hit_tempo;
    logic    hit_volume;
    logic    hit_status;
    logic    mapped;
    logic    access;
    logic    wr;
    logic    start_q;
    logic    stop_q;
    logic    loop_q;
    tempo_t  tempo_q;
    volume_t volume_q;

    // ----------------------------------------------------------
    // address decode
    // ----------------------------------------------------------
    assign hit_ctrl   = paddr == reg_ctrl;
    assign hit_tempo  = paddr == reg_tempo;
    assign hit_volume = paddr == reg_volume;
    assign hit_status = paddr == reg_status;
    assign mapped     = hit_ctrl | hit_tempo | hit_volume | hit_status;

    // the slave never stalls, so the access phase always completes
    assign access  = psel & penable;
    assign wr      = access & pwrite;
    assign pready  = 1'b1;
    assign pslverr = access & ~mapped;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            start_q  <= 1'b0;
            stop_q   <= 1'b0;
            loop_q   <= 1'b0;
            tempo_q  <= '1;
            volume_q <= '0;
        end else begin
            // start and stop are write-one strobes, high for a single cycle
            start_q <= wr & hit_ctrl & pwdata[0];
            stop_q  <= wr & hit_ctrl & pwdata[1];
            if (wr && hit_ctrl) begin
                loop_q <= pwdata[2];
            end
            if (wr && hit_tempo) begin
                tempo_q <= pwdata[23:0];
            end
            if (wr && hit_volume) begin
                volume_q <= pwdata[3:0];
            end
        end
    end

    assign ctrl = '{start: start_q, stop: stop_q, loop: loop_q,
                    tempo: tempo_q, volume: volume_q};

    // read mux, the strobes always read back as zero
    always_comb begin
        prdata = '0;
        if (hit_ctrl) begin
            prdata[2] = loop_q;
        end else if (hit_tempo) begin
            prdata[23:0] = tempo_q;
        end else if (hit_volume) begin
            prdata[3:0] = volume_q;
        end else if (hit_status) begin
            // playing in bit 13, index in 12:7, octave in 6:4, pitch in 3:0
            prdata[13:0] = status;
        end
    end

endmodule

`default_nettype wire

//--- verilog/beat_timer.sv
`timescale 1ns/1ps
`default_nettype none

module beat_timer
    import melody_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   run,
    input  tempo_t tempo,
    output logic   beat
);

    tempo_t count;

    // greater-or-equal also covers a tempo lowered below the running count
    assign beat = run & (count >= tempo);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (!run) begin
            // held at zero while idle so the first beat is a full one
            count <= '0;
        end else if (beat) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- verilog/melody_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module melody_fsm
    import melody_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  player_ctrl_t ctrl,
    input  logic         beat,
    output logic         playing,
    output note_index_t  index
);

    localparam note_index_t last_index = note_index_t'(song_len - 1);

    player_state_t state;

    assign playing = state == st_play;

    // priority is stop, then start, then beat
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
            index <= '0;
        end else if (ctrl.stop) begin
            state <= st_idle;
        end else if (ctrl.start) begin
            // also restarts a song that is already playing
            state <= st_play;
            index <= '0;
        end else begin
            case (state)
                st_play: begin
                    if (beat) begin
                        if (index != last_index) begin
                            index <= index + 1'b1;
                        end else if (ctrl.loop) begin
                            index <= '0;
                        end else begin
                            // one-shot end, the index stays on the last note
                            state <= st_idle;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/melody_pkg.sv
`default_nettype none

package melody_pkg;

    // ----------------------------------------------------------
    // widths that carry a meaning
    // ----------------------------------------------------------

    // semitone code, 0 is C and 11 is B, 12 means no tone
    typedef logic [3:0]  pitch_t;
    typedef logic [2:0]  octave_t;
    typedef logic [5:0]  note_index_t;
    // beat length in clock cycles, minus one
    typedef logic [23:0] tempo_t;
    // right shift applied to full scale
    typedef logic [3:0]  volume_t;

    typedef struct packed {
        octave_t octave;
        pitch_t  pitch;
    } note_t;

    // one-cycle start and stop pulses plus the stored settings
    typedef struct packed {
        logic    start;
        logic    stop;
        logic    loop;
        tempo_t  tempo;
        volume_t volume;
    } player_ctrl_t;

    // the field order matches the STATUS register bit layout
    typedef struct packed {
        logic        playing;
        note_index_t index;
        note_t       note;
    } player_status_t;

    typedef enum logic {
        st_idle,
        st_play
    } player_state_t;

    localparam pitch_t pitch_silence = 4'd12;
    localparam int     song_len      = 62;

    // APB register offsets
    localparam logic [31:0] reg_ctrl   = 32'h0;
    localparam logic [31:0] reg_tempo  = 32'h4;
    localparam logic [31:0] reg_volume = 32'h8;
    localparam logic [31:0] reg_status = 32'hC;

endpackage

`default_nettype wire

//--- verilog/melody_player.sv
`timescale 1ns/1ps
`default_nettype none

module melody_player
    import melody_pkg::*;
#(
    parameter int clk_mhz = 50,
    parameter int w_sound = 16
)
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [31:0]               paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    output logic signed [w_sound-1:0] sound,
    output logic [7:0]                abcdefgh
);

    player_ctrl_t ctrl;
    logic         beat;

    // playing and index come from the FSM, the note from the ROM
    wire player_status_t status;

    // ----------------------------------------------------------
    // control path
    // ----------------------------------------------------------
    apb_regs apb_regs_i (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ctrl    (ctrl),
        .status  (status)
    );

    beat_timer beat_timer_i (
        .clk   (clk),
        .rst   (rst),
        .run   (status.playing),
        .tempo (ctrl.tempo),
        .beat  (beat)
    );

    melody_fsm melody_fsm_i (
        .clk     (clk),
        .rst     (rst),
        .ctrl    (ctrl),
        .beat    (beat),
        .playing (status.playing),
        .index   (status.index)
    );

    melody_rom melody_rom_i (
        .index (status.index),
        .note  (status.note)
    );

    // ----------------------------------------------------------
    // outputs to the speaker and the digit
    // ----------------------------------------------------------
    tone_gen #(
        .clk_mhz (clk_mhz),
        .w_sound (w_sound)
    ) tone_gen_i (
        .clk     (clk),
        .rst     (rst),
        .playing (status.playing),
        .note    (status.note),
        .volume  (ctrl.volume),
        .sound   (sound)
    );

    note_display note_display_i (
        .clk      (clk),
        .rst      (rst),
        .playing  (status.playing),
        .pitch    (status.note.pitch),
        .abcdefgh (abcdefgh)
    );

endmodule

`default_nettype wire

//--- verilog/melody_rom.sv
`timescale 1ns/1ps
`default_nettype none

module melody_rom
    import melody_pkg::*;
(
    input  note_index_t index,
    output note_t       note
);

    // pitch names, sharps carry an s
    localparam pitch_t p_c  = 4'd0;
    localparam pitch_t p_d  = 4'd2;
    localparam pitch_t p_ds = 4'd3;
    localparam pitch_t p_e  = 4'd4;
    localparam pitch_t p_f  = 4'd5;
    localparam pitch_t p_g  = 4'd7;
    localparam pitch_t p_gs = 4'd8;
    localparam pitch_t p_a  = 4'd9;
    localparam pitch_t p_b  = 4'd11;

    localparam octave_t lo = 3'd0;
    localparam octave_t hi = 3'd1;

    // ----------------------------------------------------------
    // song table, one row per phrase
    // ----------------------------------------------------------
    localparam note_t song [song_len] = '{
        // opening E and D sharp trill, then the fall to A
        {hi, p_e }, {hi, p_ds}, {hi, p_e }, {hi, p_ds}, {hi, p_e },
        {lo, p_b }, {hi, p_d }, {hi, p_c }, {lo, p_a }, {lo, p_a },
        {lo, p_c }, {lo, p_e }, {lo, p_a }, {lo, p_b }, {lo, p_b },
        {lo, p_e }, {lo, p_gs}, {lo, p_b }, {hi, p_c }, {hi, p_c },
        // the phrase again, with the A minor answer at the end
        {hi, p_e }, {hi, p_ds}, {hi, p_e }, {hi, p_ds}, {hi, p_e },
        {lo, p_b }, {hi, p_d }, {hi, p_c }, {lo, p_a }, {lo, p_a },
        {lo, p_c }, {lo, p_e }, {lo, p_a }, {lo, p_b }, {lo, p_b },
        {lo, p_e }, {hi, p_c }, {lo, p_b }, {lo, p_a }, {lo, p_a },
        // closing scale runs
        {lo, p_b }, {hi, p_c }, {hi, p_d }, {hi, p_e }, {hi, p_e }, {hi, p_e },
        {lo, p_g }, {hi, p_f }, {hi, p_e }, {hi, p_d }, {hi, p_d }, {hi, p_d },
        {lo, p_f }, {hi, p_e }, {hi, p_d }, {hi, p_c }, {hi, p_c }, {hi, p_c },
        {lo, p_e }, {hi, p_d }, {hi, p_c }, {lo, p_b }
    };

    // anything past the end of the table is silent
    always_comb begin
        if (index < song_len) begin
            note = song[index];
        end else begin
            note = '{octave: '0, pitch: pitch_silence};
        end
    end

endmodule

`default_nettype wire

//--- verilog/note_display.sv
`timescale 1ns/1ps
`default_nettype none

module note_display
    import melody_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       playing,
    input  pitch_t     pitch,
    output logic [7:0] abcdefgh
);

    // segment order is a to g then the dot h, which marks a sharp
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            abcdefgh <= '0;
        end else if (!playing || pitch >= pitch_silence) begin
            abcdefgh <= '0;
        end else begin
            case (pitch)
                4'd0:    abcdefgh <= 8'b1001_1100;
                4'd1:    abcdefgh <= 8'b1001_1101;
                4'd2:    abcdefgh <= 8'b0111_1010;
                4'd3:    abcdefgh <= 8'b0111_1011;
                4'd4:    abcdefgh <= 8'b1001_1110;
                4'd5:    abcdefgh <= 8'b1000_1110;
                4'd6:    abcdefgh <= 8'b1000_1111;
                4'd7:    abcdefgh <= 8'b1011_1100;
                4'd8:    abcdefgh <= 8'b1011_1101;
                4'd9:    abcdefgh <= 8'b1110_1110;
                4'd10:   abcdefgh <= 8'b1110_1111;
                // lower case b
                4'd11:   abcdefgh <= 8'b0011_1110;
                default: abcdefgh <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen
    import melody_pkg::*;
#(
    parameter int clk_mhz = 50,
    parameter int w_sound = 16
)
(
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       playing,
    input  note_t                      note,
    input  volume_t                    volume,
    output logic signed [w_sound-1:0]  sound
);

    // half period in clock cycles for each pitch of octave 0 (C4 to B4)
    function automatic longint half_cycles(int p);
        longint milli_hz;
        case (p)
            0:       milli_hz = 261626;
            1:       milli_hz = 277183;
            2:       milli_hz = 293665;
            3:       milli_hz = 311127;
            4:       milli_hz = 329628;
            5:       milli_hz = 349228;
            6:       milli_hz = 369994;
            7:       milli_hz = 391995;
            8:       milli_hz = 415305;
            9:       milli_hz = 440000;
            10:      milli_hz = 466164;
            default: milli_hz = 493883;
        endcase
        return (longint'(clk_mhz) * 64'd500_000_000) / milli_hz;
    endfunction

    // C is the lowest pitch, so it sets the counter width
    localparam int w_half = $clog2(half_cycles(0) + 1);

    logic [w_half-1:0]         half_tab [12];
    logic [w_half-1:0]         half;
    logic [w_half-1:0]         cnt;
    logic                      phase;
    logic                      active;
    note_t                     note_q;
    logic signed [w_sound-1:0] amp;

    for (genvar i = 0; i < 12; i++) begin : g_half
        assign half_tab[i] = w_half'(half_cycles(i));
    end

    // each octave up halves the period
    always_comb begin
        half = '0;
        if (note.pitch < pitch_silence) begin
            half = half_tab[note.pitch] >> note.octave;
        end
    end

    assign active = playing & (note.pitch < pitch_silence);

    // ----------------------------------------------------------
    // half-period counter and square-wave phase
    // ----------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt    <= '0;
            phase  <= 1'b0;
            note_q <= '0;
        end else begin
            note_q <= note;
            if (!active || note != note_q) begin
                // a new note begins with a fresh half period
                cnt   <= '0;
                phase <= 1'b0;
            end else if (cnt >= half - 1'b1) begin
                cnt   <= '0;
                phase <= ~phase;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // full scale is 2^(w_sound-1)-1, lowered by the volume shift
    assign amp   = {1'b0, {(w_sound - 1){1'b1}}} >>> volume;
    assign sound = !active ? '0 : (phase ? -amp : amp);

endmodule

`default_nettype wire
